// File: Makefile
TOP   = tb_exe_stage
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f exe_stage.f -Mdir $(BUILD) -o $(TOP)

run: compile
	./$(BUILD)/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) sim.log

// File: exe_stage.f
rtl/exe_pkg.sv
rtl/kogge_stone_adder.sv
rtl/barrel_shifter.sv
rtl/alu.sv
rtl/exe_stage.sv
verification/exe_stage_asserts.sv
verification/tb_exe_stage.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu
    import exe_pkg::*;
(
    input  word_t   i_a,
    input  word_t   i_b,
    input  alu_op_e i_op,
    output word_t   o_result,
    output logic    o_zero
);

    logic         sub;
    logic         shift_right;
    logic         shift_arith;
    word_t        sum;
    word_t        shifted;
    adder_flags_t flags;
    logic         slt;
    logic         sltu;

    // compares need the difference, so they subtract as well
    assign sub = (i_op == ALU_SUB) || (i_op == ALU_SLT) || (i_op == ALU_SLTU);

    // shifter controls
    assign shift_right = (i_op == ALU_SRL) || (i_op == ALU_SRA);
    assign shift_arith = (i_op == ALU_SRA);

    kogge_stone_adder u_adder (
        .i_a     (i_a),
        .i_b     (i_b),
        .i_sub   (sub),
        .o_sum   (sum),
        .o_flags (flags)
    );

    // only the low five bits of b count as the shift amount
    barrel_shifter u_shifter (
        .i_data  (i_a),
        .i_shamt (i_b[SHAMT_W-1:0]),
        .i_right (shift_right),
        .i_arith (shift_arith),
        .o_data  (shifted)
    );

    // signed less-than from sign and overflow of a - b
    assign slt  = flags.n ^ flags.v;
    // unsigned less-than is a borrow, i.e. no carry out
    assign sltu = ~flags.c;

    always_comb begin
        case (i_op)
            ALU_ADD,
            ALU_SUB: begin
                o_result = sum;
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_SLL,
            ALU_SRL,
            ALU_SRA: begin
                o_result = shifted;
            end
            ALU_SLT: begin
                o_result = {{(XLEN-1){1'b0}}, slt};
            end
            ALU_SLTU: begin
                o_result = {{(XLEN-1){1'b0}}, sltu};
            end
            // unknown encodings
            default: begin
                o_result = '0;
            end
        endcase
    end

    // zero of the sum or difference, whatever the op
    assign o_zero = flags.z;

endmodule

// File: rtl/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter
    import exe_pkg::*;
(
    input  word_t  i_data,
    input  shamt_t i_shamt,
    input  logic   i_right,
    input  logic   i_arith,
    output word_t  o_data
);

    word_t data_in;
    word_t data_last;
    logic  fill;

    // left shifts run through the right shifter on a bit-reversed word
    assign data_in = i_right ? i_data : {<<{i_data}};

    // sign fill only for arithmetic right shifts
    assign fill = i_arith & i_data[XLEN-1];

    // level j shifts by XLEN >> (j + 1), i.e. 16, 8, 4, 2, 1
    for (genvar j = 0; j < SHAMT_W; j++) begin : g_stage
        word_t d_in;
        word_t d_out;

        if (j == 0) begin : g_first
            assign d_in = data_in;
        end else begin : g_next
            assign d_in = g_stage[j-1].d_out;
        end

        assign d_out = i_shamt[SHAMT_W-1-j]
                     ? {{(XLEN >> (j + 1)){fill}}, d_in[XLEN-1:(XLEN >> (j + 1))]}
                     : d_in;
    end

    assign data_last = g_stage[SHAMT_W-1].d_out;

    // undo the reversal for left shifts
    assign o_data = i_right ? data_last : {<<{data_last}};

endmodule

// File: rtl/exe_pkg.sv
package exe_pkg;

    // data path and shift amount widths
    localparam int XLEN        = 32;
    localparam int SHAMT_W     = 5;
    // depth of the parallel-prefix tree
    localparam int PREFIX_LVLS = $clog2(XLEN);

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // bit 4 marks the ops that run the adder as a subtractor
    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_AND  = 5'b00001,
        ALU_OR   = 5'b00010,
        ALU_XOR  = 5'b00011,
        ALU_SLL  = 5'b00100,
        ALU_SRL  = 5'b00101,
        ALU_SRA  = 5'b00110,
        ALU_SUB  = 5'b10000,
        ALU_SLT  = 5'b10111,
        ALU_SLTU = 5'b11000
    } alu_op_e;

    // c set on a subtraction means no borrow
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } adder_flags_t;

    typedef struct packed {
        word_t   rs1_data;
        word_t   rs2_data;
        word_t   imm;
        logic    alu_src;
        alu_op_e alu_op;
    } exe_req_t;

    typedef struct packed {
        word_t data_addr;
        word_t data_wr;
        logic  zero;
    } exe_rsp_t;

endpackage

// File: rtl/exe_stage.sv
`timescale 1ns/1ps

module exe_stage
    import exe_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_valid,
    input  exe_req_t i_req,
    output logic     o_valid,
    output exe_rsp_t o_rsp
);

    word_t op_b;
    word_t alu_result;
    logic  alu_zero;

    // second operand is rs2 or the immediate
    assign op_b = i_req.alu_src ? i_req.imm : i_req.rs2_data;

    alu u_alu (
        .i_a      (i_req.rs1_data),
        .i_b      (op_b),
        .i_op     (i_req.alu_op),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    // one cycle pulse per strobe, no back-pressure
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // response holds until the next strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp <= '0;
        end else if (i_valid) begin
            // the ALU result doubles as the load/store address
            o_rsp.data_addr <= alu_result;
            // store data is always rs2, even when the immediate is selected
            o_rsp.data_wr   <= i_req.rs2_data;
            o_rsp.zero      <= alu_zero;
        end
    end

endmodule

// File: rtl/kogge_stone_adder.sv
`timescale 1ns/1ps

module kogge_stone_adder
    import exe_pkg::*;
(
    input  word_t        i_a,
    input  word_t        i_b,
    input  logic         i_sub,
    output word_t        o_sum,
    output adder_flags_t o_flags
);

    word_t         b_eff;
    word_t         g_bit;
    word_t         p_bit;
    logic [XLEN:0] g_init;
    logic [XLEN:0] p_init;
    logic [XLEN:0] g_grp;
    logic [XLEN:0] p_grp;
    logic [XLEN:0] carry;

    // subtraction is a + ~b + 1
    assign b_eff = i_sub ? ~i_b : i_b;

    assign g_bit = i_a & b_eff;
    assign p_bit = i_a ^ b_eff;

    // index 0 is the carry-in at position -1, index k+1 is bit k
    assign g_init = {g_bit, i_sub};
    assign p_init = {p_bit, i_sub};

    // prefix levels with spans 1, 2, 4, 8 and 16
    for (genvar l = 0; l < PREFIX_LVLS; l++) begin : g_lvl
        logic [XLEN:0] g_in;
        logic [XLEN:0] p_in;
        logic [XLEN:0] g_out;
        logic [XLEN:0] p_out;

        if (l == 0) begin : g_first
            assign g_in = g_init;
            assign p_in = p_init;
        end else begin : g_next
            assign g_in = g_lvl[l-1].g_out;
            assign p_in = g_lvl[l-1].p_out;
        end

        for (genvar k = 0; k <= XLEN; k++) begin : g_node
            if (k >= (1 << l)) begin : g_black
                // merge with the group one span below
                assign g_out[k] = g_in[k] | (p_in[k] & g_in[k - (1 << l)]);
                assign p_out[k] = p_in[k] & p_in[k - (1 << l)];
            end else begin : g_buf
                assign g_out[k] = g_in[k];
                assign p_out[k] = p_in[k];
            end
        end
    end

    assign g_grp = g_lvl[PREFIX_LVLS-1].g_out;
    assign p_grp = g_lvl[PREFIX_LVLS-1].p_out;

    // group generate at index k already reaches the carry-in for k <= 31
    assign carry[XLEN-1:0] = g_grp[XLEN-1:0];
    // top group spans bits 0..31, fold in the carry-in once more
    assign carry[XLEN] = g_grp[XLEN] | (p_grp[XLEN] & g_grp[0]);

    assign o_sum = p_bit ^ carry[XLEN-1:0];

    assign o_flags.n = o_sum[XLEN-1];
    assign o_flags.z = ~|o_sum;
    assign o_flags.c = carry[XLEN];
    // carries into and out of the sign bit disagree on overflow
    assign o_flags.v = carry[XLEN] ^ carry[XLEN-1];

endmodule

// File: verification/exe_stage_asserts.sv
`timescale 1ns/1ps

module exe_stage_asserts
    import exe_pkg::*;
(
    input logic     i_clk,
    input logic     i_reset,
    input logic     i_valid,
    input exe_req_t i_req,
    input logic     o_valid,
    input exe_rsp_t o_rsp
);

    // one result pulse per strobe, exactly one cycle later
    a_valid_latency: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !$past(i_reset) |-> (o_valid == $past(i_valid))
    ) else $error("o_valid does not follow i_valid by one cycle");

    // no result pulse out of reset
    a_reset_quiet: assert property (
        @(posedge i_clk)
        $past(i_reset) |-> !o_valid
    ) else $error("o_valid high while in reset");

    // store data is rs2 of the strobed request
    a_store_data: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_valid |-> (o_rsp.data_wr == $past(i_req.rs2_data))
    ) else $error("data_wr differs from rs2_data of the strobe");

endmodule

// File: verification/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage
    import exe_pkg::*;
;

    localparam int PERIOD       = 100;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_GAP      = 3;
    localparam int N_TIMING     = 24;
    localparam int N_ADDSUB     = 200;
    localparam int N_LOGIC      = 150;
    localparam int N_ILLEGAL    = 20;
    localparam int N_SHIFT      = 150;
    localparam int N_CMP        = 150;
    localparam int N_SRC        = 60;
    localparam int N_EDGE       = 20;
    localparam int TOTAL_STROBES = N_TIMING + N_ADDSUB + N_LOGIC + N_ILLEGAL + N_SHIFT
                                 + N_CMP + N_SRC + N_EDGE;
    // every strobe plus its longest gap, reset and drain slack, then doubled
    localparam int TIMEOUT_CYCLES = 2 * (TOTAL_STROBES * (MAX_GAP + 1) + RESET_CYCLES + 6 * 4);

    logic     i_clk = 1'b0;
    logic     i_reset;
    logic     i_valid;
    exe_req_t i_req;
    logic     o_valid;
    exe_rsp_t o_rsp;

    integer   seed;
    string    test_name;
    exe_rsp_t exp_q[$];
    exe_rsp_t exp_rsp;
    exe_rsp_t last_rsp;
    logic     strobe_seen;
    int       errors;
    int       test_errors;
    int       checks;
    int       test_strobes;

    exe_stage u_dut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_req   (i_req),
        .o_valid (o_valid),
        .o_rsp   (o_rsp)
    );

    bind exe_stage exe_stage_asserts u_asserts (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_req   (i_req),
        .o_valid (o_valid),
        .o_rsp   (o_rsp)
    );

    always #(PERIOD / 2) i_clk = ~i_clk;

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_gap();
        word_t r;
        r = rand_word();
        return int'(r % (MAX_GAP + 1));
    endfunction

    function automatic alu_op_e rand_legal_op();
        word_t r;
        alu_op_e op;
        r = rand_word();
        case (r % 10)
            0: op = ALU_ADD;
            1: op = ALU_SUB;
            2: op = ALU_AND;
            3: op = ALU_OR;
            4: op = ALU_XOR;
            5: op = ALU_SLL;
            6: op = ALU_SRL;
            7: op = ALU_SRA;
            8: op = ALU_SLT;
            default: op = ALU_SLTU;
        endcase
        return op;
    endfunction

    function automatic alu_op_e rand_illegal_op();
        word_t r;
        logic [4:0] code;
        do begin
            r = rand_word();
            code = r[4:0];
        end while (code inside {ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
                                ALU_SRA, ALU_SUB, ALU_SLT, ALU_SLTU});
        return alu_op_e'(code);
    endfunction

    // the unused one of rs2 and imm gets random bits
    function automatic exe_req_t make_req(word_t a, word_t b, alu_op_e op, logic src);
        exe_req_t req;
        req.rs1_data = a;
        req.alu_op   = op;
        req.alu_src  = src;
        if (src) begin
            req.imm      = b;
            req.rs2_data = rand_word();
        end else begin
            req.rs2_data = b;
            req.imm      = rand_word();
        end
        return req;
    endfunction

    // reference model of the execute stage
    function automatic exe_rsp_t model_rsp(exe_req_t req);
        exe_rsp_t rsp;
        word_t a;
        word_t b;
        word_t sum;
        word_t diff;
        logic [4:0] sh;
        a    = req.rs1_data;
        b    = req.alu_src ? req.imm : req.rs2_data;
        sh   = b[4:0];
        sum  = a + b;
        diff = a - b;
        case (req.alu_op)
            ALU_ADD:  rsp.data_addr = sum;
            ALU_SUB:  rsp.data_addr = diff;
            ALU_AND:  rsp.data_addr = a & b;
            ALU_OR:   rsp.data_addr = a | b;
            ALU_XOR:  rsp.data_addr = a ^ b;
            ALU_SLL:  rsp.data_addr = a << sh;
            ALU_SRL:  rsp.data_addr = a >> sh;
            ALU_SRA:  rsp.data_addr = word_t'($signed(a) >>> sh);
            ALU_SLT:  rsp.data_addr = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: rsp.data_addr = (a < b) ? 32'd1 : 32'd0;
            default:  rsp.data_addr = '0;
        endcase
        // zero flag reflects the adder, which subtracts only for sub and compares
        if (req.alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU}) begin
            rsp.zero = (diff == '0);
        end else begin
            rsp.zero = (sum == '0);
        end
        rsp.data_wr = req.rs2_data;
        return rsp;
    endfunction

    task automatic send(input exe_req_t req, input int gap);
        i_valid = 1'b1;
        i_req   = req;
        exp_q.push_back(model_rsp(req));
        test_strobes++;
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_valid = 1'b0;
        // garbage on the bus while idle
        i_req.rs1_data = rand_word();
        i_req.rs2_data = rand_word();
        i_req.imm      = rand_word();
        repeat (gap) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_errors  = 0;
        test_strobes = 0;
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #DRIVE_DELAY;
        $display("test %s done: %0d strobes, %0d errors", test_name, test_strobes, test_errors);
    endtask

    // a strobe under reset produces no result
    always @(posedge i_clk) begin
        strobe_seen <= i_valid && !i_reset;
    end

    // outputs settle after the rising edge, so compare on the falling edge
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (o_valid !== strobe_seen) begin
                errors++;
                test_errors++;
                $display("error %s: o_valid expected %b actual %b",
                         test_name, strobe_seen, o_valid);
            end
            if (o_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    test_errors++;
                    $display("%s: a result appeared with no strobe pending", test_name);
                end else begin
                    exp_rsp = exp_q.pop_front();
                    checks++;
                    if (o_rsp !== exp_rsp) begin
                        errors++;
                        test_errors++;
                        $display("error %s: expected %h actual %h", test_name, exp_rsp, o_rsp);
                    end
                    last_rsp = exp_rsp;
                end
            end else begin
                // a missing pulse drops its entry so the run keeps going
                if (strobe_seen && exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                if (o_rsp !== last_rsp) begin
                    errors++;
                    test_errors++;
                    $display("error %s: held response expected %h actual %h",
                             test_name, last_rsp, o_rsp);
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * PERIOD);
        $display("watchdog: the run did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        word_t a;
        word_t b;
        word_t r;
        seed        = 32'he8a7c110;
        i_reset     = 1'b1;
        // strobes keep coming while in reset and must be ignored
        i_valid     = 1'b1;
        i_req       = make_req(rand_word(), rand_word(), rand_legal_op(), 1'b0);
        strobe_seen = 1'b0;
        last_rsp    = '0;
        errors      = 0;
        checks      = 0;
        start_test("reset_timing");
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        i_valid = 1'b0;
        if (o_valid !== 1'b0 || o_rsp !== '0) begin
            errors++;
            test_errors++;
            $display("error %s: expected %h actual %h", test_name, 66'h0, {o_valid, o_rsp});
        end
        // bursts of back to back strobes mixed with random gaps
        for (int k = 0; k < N_TIMING; k++) begin
            send(make_req(rand_word(), rand_word(), ALU_ADD, 1'b0),
                 (k % 6 < 3) ? 0 : rand_gap());
        end
        finish_test();

        start_test("add_sub");
        send(make_req(32'h7fffffff, 32'h00000001, ALU_ADD, 1'b0), 0);
        send(make_req(32'h80000000, 32'h00000001, ALU_SUB, 1'b0), 0);
        send(make_req(32'hffffffff, 32'h00000001, ALU_ADD, 1'b0), 1);
        send(make_req(32'h80000000, 32'h80000000, ALU_ADD, 1'b0), 0);
        send(make_req(32'h00000000, 32'h00000001, ALU_SUB, 1'b0), 0);
        for (int k = 0; k < N_EDGE - 5; k++) begin
            a = rand_word();
            send(make_req(a, a, ALU_SUB, 1'b0), rand_gap());
        end
        for (int k = 0; k < N_ADDSUB; k++) begin
            r = rand_word();
            send(make_req(rand_word(), rand_word(), r[0] ? ALU_SUB : ALU_ADD, 1'b0), rand_gap());
        end
        finish_test();

        start_test("logic");
        send(make_req(32'h00000000, 32'hffffffff, ALU_AND, 1'b0), 0);
        send(make_req(32'hffffffff, 32'hffffffff, ALU_OR, 1'b0), 0);
        send(make_req(32'hffffffff, 32'hffffffff, ALU_XOR, 1'b0), 0);
        send(make_req(32'h00000000, 32'h00000000, ALU_OR, 1'b0), 0);
        for (int k = 0; k < N_LOGIC; k++) begin
            r = rand_word();
            send(make_req(rand_word(), rand_word(),
                          (r % 3 == 0) ? ALU_AND : ((r % 3 == 1) ? ALU_OR : ALU_XOR), 1'b0),
                 rand_gap());
        end
        for (int k = 0; k < N_ILLEGAL; k++) begin
            send(make_req(rand_word(), rand_word(), rand_illegal_op(), 1'b0), rand_gap());
        end
        finish_test();

        start_test("shift");
        for (int k = 0; k < N_SHIFT; k++) begin
            a = rand_word();
            // half the words are negative to exercise the sign fill
            if (k % 2 == 1) begin
                a[31] = 1'b1;
            end
            r = rand_word();
            send(make_req(a, rand_word(),
                          (r % 3 == 0) ? ALU_SLL : ((r % 3 == 1) ? ALU_SRL : ALU_SRA), 1'b0),
                 rand_gap());
        end
        finish_test();

        start_test("compare");
        for (int k = 0; k < N_CMP; k++) begin
            a = rand_word();
            b = rand_word();
            // opposite signs, where signed and unsigned order disagree
            if (k % 3 == 0) begin
                a[31] = k[2];
                b[31] = ~k[2];
            end
            r = rand_word();
            send(make_req(a, b, r[0] ? ALU_SLTU : ALU_SLT, 1'b0), rand_gap());
        end
        finish_test();

        start_test("alu_src");
        for (int k = 0; k < N_SRC; k++) begin
            send(make_req(rand_word(), rand_word(), rand_legal_op(), 1'b1), rand_gap());
        end
        finish_test();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
